/* hw/zx_ula_defines.svh */
`ifndef ZX_ULA_DEFINES_SVH
`define ZX_ULA_DEFINES_SVH

// pentagon raster, in pixels and lines
`define H_AREA          256
`define V_AREA          192
`define SCREEN_DELAY    8
`define H_TOTAL         448
`define V_TOTAL         320
`define H_BLANK_START   317
`define H_BLANK_END     402
`define H_SYNC_START    329
`define H_SYNC_END      362
`define V_SYNC_START    248
`define V_SYNC_END      256

// frame interrupt
`define INT_V           239
`define INT_H           316
`define INT_LEN         32    // in cpu clocks

// port decode
`define PORT_7FFD_HI    2'b01 // xa[15:14]
`define IM2_VECTOR      8'hff

// memory map
`define BANK_SCREEN_A   3'd5
`define BANK_SCREEN_B   3'd7
`define BANK_4000       3'd5
`define BANK_8000       3'd2
`define ROM_BANK_48     3'd0
`define ROM_BANK_128    3'd1

`endif

/* hw/zx_ula_pkg.sv */
package zx_ula_pkg;

	typedef logic [10:0] subpix_t;   // clk28 ticks within a line
	typedef logic [8:0]  hcount_t;
	typedef logic [8:0]  vcount_t;
	typedef logic [7:0]  byte_t;
	typedef logic [16:0] vaddr_t;    // 128k video ram
	typedef logic [2:0]  bank_t;
	typedef logic [15:0] cpu_addr_t;

	// screen fetch alternates bitmap and attribute reads
	typedef enum logic {
		STEP_BITMAP,
		STEP_ATTR
	} fetch_step_e;

endpackage

/* hw/zx_raster_timer.sv */
`timescale 1ns/1ps
`include "zx_ula_defines.svh"

module zx_raster_timer import zx_ula_pkg::*; (
	input  logic    clk28,
	input  logic    rst_n0,
	output subpix_t hc0,
	output hcount_t hc,
	output vcount_t vc,
	output logic    line_end,
	output logic    frame_end,
	output logic    blank,
	output logic    hsync0,
	output logic    vsync0,
	output logic    blink,
	output logic    int_begin
);

	logic [4:0] frame_cnt;

	assign hc = hc0[10:2];
	assign line_end = hc0 == subpix_t'(`H_TOTAL * 4 - 1);
	assign frame_end = line_end && vc == vcount_t'(`V_TOTAL - 1);

	assign hsync0 = hc >= hcount_t'(`H_SYNC_START) && hc < hcount_t'(`H_SYNC_END);
	assign vsync0 = vc >= vcount_t'(`V_SYNC_START) && vc < vcount_t'(`V_SYNC_END);
	assign blank = vsync0 ||
		(hc >= hcount_t'(`H_BLANK_START) && hc < hcount_t'(`H_BLANK_END));

	assign int_begin = vc == vcount_t'(`INT_V) && hc == hcount_t'(`INT_H);
	assign blink = frame_cnt[4]; // ~1.5 hz flash

	always_ff @(posedge clk28 or negedge rst_n0) begin
		if (!rst_n0) begin
			hc0 <= '0;
			vc <= '0;
		end
		else if (line_end) begin
			hc0 <= '0;
			if (frame_end)
				vc <= '0;
			else
				vc <= vc + 1'b1;
		end
		else begin
			hc0 <= hc0 + 1'b1;
		end
	end

	always_ff @(posedge clk28 or negedge rst_n0) begin
		if (!rst_n0)
			frame_cnt <= '0;
		else if (frame_end)
			frame_cnt <= frame_cnt + 1'b1;
	end

endmodule

/* hw/zx_screen_fetch.sv */
`timescale 1ns/1ps
`include "zx_ula_defines.svh"

module zx_screen_fetch import zx_ula_pkg::*; (
	input  logic        clk28,
	input  logic        rst_n0,
	input  subpix_t     hc0,
	input  hcount_t     hc,
	input  vcount_t     vc,
	input  logic        line_end,
	input  logic        fetch_grant,
	input  byte_t       vd_in,
	input  logic [2:0]  border,
	output logic        fetch_req,
	output logic [13:0] fetch_addr,
	output logic        pixel,
	output byte_t       attr
);

	fetch_step_e step;
	byte_t       bitmap;
	byte_t       bitmap_next;
	byte_t       attr_next;
	byte_t       attr_border;
	logic [13:0] bitmap_addr;
	logic [13:0] attr_addr;
	logic        phase;
	logic        step_reset;
	logic        screen_show;
	logic        screen_update;
	logic        border_update;

	assign phase = hc0[0]; // 14 mhz
	assign step_reset = (&hc0[4:0]) || line_end; // last tick of a character

	assign fetch_req = vc < vcount_t'(`V_AREA) && (hc < hcount_t'(`H_AREA) || line_end);

	// shifter output runs SCREEN_DELAY pixels behind the fetch
	assign screen_show = vc < vcount_t'(`V_AREA) &&
		hc0 >= subpix_t'(`SCREEN_DELAY * 4 - 2) &&
		hc0 < subpix_t'((`H_AREA + `SCREEN_DELAY) * 4 - 2);
	assign screen_update = vc < vcount_t'(`V_AREA) && hc <= hcount_t'(`H_AREA) &&
		hc0[4:0] == 5'b11110;
	assign border_update = !screen_show && hc0[4:0] == 5'b11110;

	// spectrum interleaved layout
	assign bitmap_addr = {1'b0, vc[7:6], vc[2:0], vc[5:3], hc[7:3]};
	assign attr_addr = {4'b0110, vc[7:3], hc[7:3]};
	assign fetch_addr = (step == STEP_BITMAP) ? bitmap_addr : attr_addr;

	assign attr_border = {2'b00, border, 3'b000}; // border as paper
	assign pixel = bitmap[7];

	always_ff @(posedge clk28 or negedge rst_n0) begin
		if (!rst_n0) begin
			step <= STEP_BITMAP;
			bitmap_next <= '0;
			attr_next <= '0;
		end
		else if (phase) begin
			if (fetch_grant) begin
				if (step == STEP_BITMAP)
					bitmap_next <= vd_in;
				else
					attr_next <= vd_in;
			end
			if (fetch_grant && step == STEP_BITMAP && !step_reset)
				step <= STEP_ATTR;
			else if (fetch_grant || step_reset)
				step <= STEP_BITMAP;
		end
	end

	always_ff @(posedge clk28 or negedge rst_n0) begin
		if (!rst_n0) begin
			bitmap <= '0;
			attr <= '0;
		end
		else begin
			if (border_update)
				attr <= attr_border;
			else if (screen_update)
				attr <= attr_next;

			if (screen_update)
				bitmap <= bitmap_next;
			else if (hc0[1:0] == 2'b10)
				bitmap <= {bitmap[6:0], 1'b0}; // one pixel per 4 ticks
		end
	end

endmodule

/* hw/zx_video_out.sv */
`timescale 1ns/1ps

module zx_video_out import zx_ula_pkg::*; (
	input  logic       clk28,
	input  logic       pixel,
	input  logic       blank,
	input  logic       hsync0,
	input  logic       vsync0,
	input  logic       blink,
	input  byte_t      attr,
	output logic [1:0] r,
	output logic [1:0] g,
	output logic [1:0] b,
	output logic       csync,
	output logic       hsync,
	output logic       vsync
);

	logic [2:0] grb;
	logic       ink;
	logic       bright;

	assign ink = pixel ^ (attr[7] & blink); // flash swaps ink and paper
	assign grb = ink ? attr[2:0] : attr[5:3];
	assign bright = attr[6] & (|grb); // black stays black

	always_ff @(posedge clk28) begin
		if (blank) begin
			r <= 2'b00;
			g <= 2'b00;
			b <= 2'b00;
		end
		else begin
			g <= {grb[2], bright};
			r <= {grb[1], bright};
			b <= {grb[0], bright};
		end
		csync <= ~(hsync0 ^ vsync0);
		hsync <= hsync0;
		vsync <= vsync0;
	end

endmodule

/* hw/zx_cpu_timing.sv */
`timescale 1ns/1ps
`include "zx_ula_defines.svh"

module zx_cpu_timing import zx_ula_pkg::*; (
	input  logic    clk28,
	input  logic    rst_n0,
	input  hcount_t hc,
	input  vcount_t vc,
	input  logic    int_begin,
	output logic    clkcpu,
	output logic    n_clkcpu,
	output logic    cpu_edge,
	output logic    n_int,
	output logic    n_rstcpu
);

	logic       clkcpu_prev;
	logic       int_pend;
	logic [4:0] int_cnt;

	// 3.5 mhz, moved off the posedge so cpu_edge is seen once
	always_ff @(negedge clk28 or negedge rst_n0) begin
		if (!rst_n0) begin
			clkcpu <= 1'b0;
			clkcpu_prev <= 1'b0;
		end
		else begin
			clkcpu_prev <= clkcpu;
			clkcpu <= hc[0];
		end
	end

	assign n_clkcpu = ~clkcpu;
	assign cpu_edge = clkcpu && !clkcpu_prev;

	always_ff @(posedge clk28 or negedge rst_n0) begin
		if (!rst_n0) begin
			int_pend <= 1'b0;
			int_cnt <= '0;
			n_int <= 1'b1;
		end
		else begin
			if (int_begin)
				int_pend <= 1'b1;
			if (cpu_edge) begin
				if (int_pend && n_int) begin
					n_int <= 1'b0; // aligned to cpu clock
					int_pend <= 1'b0;
					int_cnt <= '0;
				end
				else if (!n_int) begin
					if (int_cnt == 5'(`INT_LEN - 1)) begin
						n_int <= 1'b1;
						int_cnt <= '0;
					end
					else begin
						int_cnt <= int_cnt + 1'b1;
					end
				end
			end
		end
	end

	always_ff @(posedge clk28 or negedge rst_n0) begin
		if (!rst_n0)
			n_rstcpu <= 1'b0;
		else if (vc[0])
			n_rstcpu <= 1'b1; // hold cpu for a line after reset
	end

endmodule

/* hw/zx_io_ports.sv */
`timescale 1ns/1ps
`include "zx_ula_defines.svh"

module zx_io_ports import zx_ula_pkg::*; (
	input  logic       clk28,
	input  logic       rst_n0,
	input  cpu_addr_t  xa,
	input  byte_t      cpu_din,
	input  logic       n_rd,
	input  logic       n_wr,
	input  logic       n_m1,
	input  logic       n_iorqge,
	input  logic       cpu_edge,
	input  logic [4:0] kd,
	input  logic       tape_in,
	output logic [2:0] border,
	output logic       beeper,
	output logic       tape_out,
	output bank_t      ram_bank,
	output logic       screen_bank,
	output logic       rom_bank,
	input  logic       cpu_ram_rd,
	input  byte_t      vd_in,
	output byte_t      cpu_dout,
	output logic       cpu_dout_en
);

	logic  n_iorqge_d;
	logic  n_ioreq;
	logic  port_fe_cs;
	logic  port_7ffd_cs;
	logic  int_ack;
	logic  lock_7ffd;
	logic  fe_rd;
	logic  ram_rd;
	byte_t fe_data;

	// iorq must hold for two ticks and not be an m1 cycle
	assign n_ioreq = ~n_m1 | n_iorqge | n_iorqge_d;
	assign port_fe_cs = !n_ioreq && !xa[0];
	assign port_7ffd_cs = !n_ioreq && !xa[1] && xa[15:14] == `PORT_7FFD_HI;
	assign int_ack = !n_iorqge && !n_m1; // im2 vector read

	assign fe_data = {1'b1, tape_in, 1'b1, kd};

	always_ff @(posedge clk28 or negedge rst_n0) begin
		if (!rst_n0)
			n_iorqge_d <= 1'b1;
		else
			n_iorqge_d <= n_iorqge;
	end

	always_ff @(posedge clk28 or negedge rst_n0) begin
		if (!rst_n0) begin
			border <= '0;
			beeper <= 1'b0;
			tape_out <= 1'b0;
		end
		else if (port_fe_cs && !n_wr && cpu_edge) begin // border changes in step with cpu
			beeper <= cpu_din[4];
			tape_out <= cpu_din[3];
			border <= cpu_din[2:0];
		end
	end

	always_ff @(posedge clk28 or negedge rst_n0) begin
		if (!rst_n0) begin
			ram_bank <= '0;
			screen_bank <= 1'b0;
			rom_bank <= 1'b0;
			lock_7ffd <= 1'b0;
		end
		else if (port_7ffd_cs && !n_wr && !lock_7ffd) begin
			ram_bank <= cpu_din[2:0];
			screen_bank <= cpu_din[3];
			rom_bank <= cpu_din[4];
			lock_7ffd <= cpu_din[5]; // until next reset
		end
	end

	always_ff @(posedge clk28 or negedge rst_n0) begin
		if (!rst_n0) begin
			fe_rd <= 1'b0;
			ram_rd <= 1'b0;
			cpu_dout_en <= 1'b0;
		end
		else begin
			fe_rd <= port_fe_cs && !n_rd;
			ram_rd <= cpu_ram_rd;
			cpu_dout_en <= (port_fe_cs && !n_rd) || cpu_ram_rd || int_ack;
		end
	end

	assign cpu_dout = fe_rd ? fe_data :
		ram_rd ? vd_in :
		`IM2_VECTOR;

endmodule

/* hw/zx_mem_arbiter.sv */
`timescale 1ns/1ps
`include "zx_ula_defines.svh"

module zx_mem_arbiter import zx_ula_pkg::*; (
	input  logic        clk28,
	input  logic        rst_n0,
	input  cpu_addr_t   xa,
	input  byte_t       cpu_din,
	input  logic        n_mreq,
	input  logic        n_rd,
	input  logic        n_wr,
	input  logic        n_rfsh,
	input  logic        n_iorqge,
	input  logic        fetch_req,
	input  logic [13:0] fetch_addr,
	input  logic        screen_bank,
	input  logic        rom_bank,
	input  bank_t       ram_bank,
	output logic        fetch_grant,
	output logic        cpu_ram_rd,
	output vaddr_t      va,
	output byte_t       vd_out,
	output logic        vd_oe,
	output logic        n_vrd,
	output logic        n_vwr,
	output logic        n_romcs,
	output logic [2:0]  ra
);

	logic  romreq;
	logic  ramreq;
	logic  ramreq_wr;
	logic  cpu_mem;
	logic  rom_area;
	logic  cpu_wr;
	bank_t scr_bank;
	bank_t cpu_bank;

	assign cpu_mem = !n_mreq && n_rfsh; // refresh never reaches ram
	assign rom_area = xa[15:14] == 2'b00;

	always_ff @(posedge clk28 or negedge rst_n0) begin
		if (!rst_n0) begin
			fetch_grant <= 1'b0;
			romreq <= 1'b0;
			ramreq <= 1'b0;
			ramreq_wr <= 1'b0;
		end
		else begin
			fetch_grant <= fetch_req && ((n_iorqge && n_mreq) || !n_rfsh); // bus idle
			romreq <= cpu_mem && rom_area;
			ramreq <= cpu_mem && !rom_area;
			ramreq_wr <= cpu_mem && !rom_area && !n_wr;
		end
	end

	assign scr_bank = screen_bank ? `BANK_SCREEN_B : `BANK_SCREEN_A;
	assign cpu_bank = (xa[15:14] == 2'b01) ? `BANK_4000 :
		(xa[15:14] == 2'b10) ? `BANK_8000 :
		ram_bank;

	assign va = fetch_grant ? {scr_bank, fetch_addr} : {cpu_bank, xa[13:0]};
	assign ra = rom_bank ? `ROM_BANK_128 : `ROM_BANK_48;

	assign cpu_wr = ramreq_wr && !n_wr;
	assign cpu_ram_rd = ramreq && !n_rd;

	assign n_romcs = !(romreq && !n_mreq);
	assign n_vrd = !(cpu_ram_rd || fetch_grant);
	assign n_vwr = !cpu_wr;
	assign vd_oe = cpu_wr;
	assign vd_out = cpu_din;

endmodule

/* hw/zx_ula.sv */
`timescale 1ns/1ps

module zx_ula import zx_ula_pkg::*; (
	input  logic       clk28,
	input  logic       rst_n0,
	input  cpu_addr_t  xa,
	input  byte_t      cpu_din,
	output byte_t      cpu_dout,
	output logic       cpu_dout_en,
	input  logic       n_rd,
	input  logic       n_wr,
	input  logic       n_mreq,
	input  logic       n_iorqge,
	input  logic       n_m1,
	input  logic       n_rfsh,
	output logic       clkcpu,
	output logic       n_clkcpu,
	output logic       n_int,
	output logic       n_rstcpu,
	output vaddr_t     va,
	input  byte_t      vd_in,
	output byte_t      vd_out,
	output logic       vd_oe,
	output logic       n_vrd,
	output logic       n_vwr,
	output logic       n_romcs,
	output logic [2:0] ra,
	input  logic [4:0] kd,
	input  logic       tape_in,
	output logic       beeper,
	output logic       tape_out,
	output logic [1:0] r,
	output logic [1:0] g,
	output logic [1:0] b,
	output logic       csync,
	output logic       hsync,
	output logic       vsync
);

	subpix_t     hc0;
	hcount_t     hc;
	vcount_t     vc;
	logic        line_end;
	logic        blank;
	logic        hsync0;
	logic        vsync0;
	logic        blink;
	logic        int_begin;
	logic        fetch_req;
	logic        fetch_grant;
	logic [13:0] fetch_addr;
	logic        pixel;
	byte_t       attr;
	logic [2:0]  border;
	bank_t       ram_bank;
	logic        screen_bank;
	logic        rom_bank;
	logic        cpu_edge;
	logic        cpu_ram_rd;

	zx_raster_timer i_raster (
		.clk28(clk28), .rst_n0(rst_n0), .hc0(hc0), .hc(hc), .vc(vc),
		.line_end(line_end), .frame_end(), .blank(blank), .hsync0(hsync0),
		.vsync0(vsync0), .blink(blink), .int_begin(int_begin)
	);

	zx_screen_fetch i_fetch (
		.clk28(clk28), .rst_n0(rst_n0), .hc0(hc0), .hc(hc), .vc(vc),
		.line_end(line_end), .fetch_grant(fetch_grant), .vd_in(vd_in),
		.border(border), .fetch_req(fetch_req), .fetch_addr(fetch_addr),
		.pixel(pixel), .attr(attr)
	);

	zx_video_out i_video (
		.clk28(clk28), .pixel(pixel), .blank(blank), .hsync0(hsync0),
		.vsync0(vsync0), .blink(blink), .attr(attr), .r(r), .g(g), .b(b),
		.csync(csync), .hsync(hsync), .vsync(vsync)
	);

	zx_cpu_timing i_cpu_timing (
		.clk28(clk28), .rst_n0(rst_n0), .hc(hc), .vc(vc), .int_begin(int_begin),
		.clkcpu(clkcpu), .n_clkcpu(n_clkcpu), .cpu_edge(cpu_edge),
		.n_int(n_int), .n_rstcpu(n_rstcpu)
	);

	zx_io_ports i_io (
		.clk28(clk28), .rst_n0(rst_n0), .xa(xa), .cpu_din(cpu_din),
		.n_rd(n_rd), .n_wr(n_wr), .n_m1(n_m1), .n_iorqge(n_iorqge),
		.cpu_edge(cpu_edge), .kd(kd), .tape_in(tape_in), .border(border),
		.beeper(beeper), .tape_out(tape_out), .ram_bank(ram_bank),
		.screen_bank(screen_bank), .rom_bank(rom_bank), .cpu_ram_rd(cpu_ram_rd),
		.vd_in(vd_in), .cpu_dout(cpu_dout), .cpu_dout_en(cpu_dout_en)
	);

	zx_mem_arbiter i_arbiter (
		.clk28(clk28), .rst_n0(rst_n0), .xa(xa), .cpu_din(cpu_din),
		.n_mreq(n_mreq), .n_rd(n_rd), .n_wr(n_wr), .n_rfsh(n_rfsh),
		.n_iorqge(n_iorqge), .fetch_req(fetch_req), .fetch_addr(fetch_addr),
		.screen_bank(screen_bank), .rom_bank(rom_bank), .ram_bank(ram_bank),
		.fetch_grant(fetch_grant), .cpu_ram_rd(cpu_ram_rd), .va(va),
		.vd_out(vd_out), .vd_oe(vd_oe), .n_vrd(n_vrd), .n_vwr(n_vwr),
		.n_romcs(n_romcs), .ra(ra)
	);

endmodule

/* verification/zx_ula_tb_tasks.svh */
task automatic write_port(input cpu_addr_t addr, input byte_t data);
	xa = addr;
	cpu_din = data;
	n_iorqge = 1'b0;
	n_wr = 1'b0;
	repeat (2 * CPU_PERIOD + 2) @(negedge clk28); // covers a cpu edge after qualification
	n_iorqge = 1'b1;
	n_wr = 1'b1;
	@(negedge clk28);
endtask

// m1 low makes this an im2 acknowledge instead of a port read
task automatic read_port(input cpu_addr_t addr, input logic m1, output byte_t data);
	int c;
	xa = addr;
	n_m1 = m1;
	n_rd = ~m1;
	n_iorqge = 1'b0;
	wait_level("cpu_dout_en", 1'b1, 8, c);
	data = cpu_dout;
	n_iorqge = 1'b1;
	n_rd = 1'b1;
	n_m1 = 1'b1;
	wait_level("cpu_dout_en", 1'b0, 8, c);
endtask

task automatic write_mem(input cpu_addr_t addr, input byte_t data);
	int c;
	xa = addr;
	cpu_din = data;
	n_mreq = 1'b0;
	n_wr = 1'b0;
	wait_level("n_vwr", 1'b0, 8, c);
	@(negedge clk28); // ram model stores on the edge in between
	n_mreq = 1'b1;
	n_wr = 1'b1;
	@(negedge clk28);
endtask

task automatic read_mem(input cpu_addr_t addr, output byte_t data);
	int c;
	xa = addr;
	n_mreq = 1'b0;
	n_rd = 1'b0;
	wait_level("cpu_dout_en", 1'b1, 8, c);
	data = cpu_dout;
	if (n_vrd !== 1'b0)
		report_mismatch("n_vrd high during ram read");
	n_mreq = 1'b1;
	n_rd = 1'b1;
	wait_level("cpu_dout_en", 1'b0, 8, c);
endtask

task automatic read_rom(input cpu_addr_t addr, output byte_t data, output logic [2:0] sel);
	int c;
	xa = addr;
	n_mreq = 1'b0;
	n_rd = 1'b0;
	wait_level("n_romcs", 1'b0, 8, c);
	data = rom_q;
	sel = ra;
	n_mreq = 1'b1;
	n_rd = 1'b1;
	@(negedge clk28);
endtask

// vsync is seen one tick into line V_SYNC_START
task automatic goto_raster(input int line, input int col);
	int c;
	wait_level("vsync", 1'b0, FRAME_CYCLES, c);
	wait_level("vsync", 1'b1, FRAME_CYCLES, c);
	repeat (((line + `V_TOTAL - `V_SYNC_START) % `V_TOTAL) * LINE_CYCLES + col * 4)
		@(negedge clk28);
endtask

function automatic logic [5:0] colour_of(input logic [2:0] grb, input logic bright);
	colour_of = {grb[1], bright, grb[2], bright, grb[0], bright}; // {r, g, b}
endfunction

task automatic reset_state();
	int c;
	if (n_int !== 1'b1 || n_romcs !== 1'b1 || n_vwr !== 1'b1 || n_vrd !== 1'b1)
		report_mismatch("n_int, n_romcs, n_vrd or n_vwr not high after reset");
	if (cpu_dout_en !== 1'b0)
		report_mismatch("cpu_dout_en not low after reset");
	if (n_rstcpu !== 1'b0)
		report_mismatch("n_rstcpu released during first line");
	if ({r, g, b} !== 6'd0)
		report_mismatch($sformatf("rgb %b after reset, expected zero", {r, g, b}));
	wait_level("n_rstcpu", 1'b1, 2 * LINE_CYCLES, c);
endtask

task automatic port_fe();
	byte_t d;
	byte_t q;
	d = byte_t'($urandom);
	kd = 5'($urandom);
	tape_in = 1'($urandom);
	write_port(16'h00fe, d);
	if (beeper !== d[4] || tape_out !== d[3])
		report_mismatch($sformatf("beeper %b tape_out %b after #fe write %h",
			beeper, tape_out, d));
	goto_raster(200, 160);
	if ({r, g, b} !== colour_of(d[2:0], 1'b0))
		report_mismatch($sformatf("border rgb %b, expected %b", {r, g, b},
			colour_of(d[2:0], 1'b0)));
	if (csync !== 1'b1)
		report_mismatch("csync low outside sync");
	read_port(16'h00fe, 1'b1, q);
	if (q !== {1'b1, tape_in, 1'b1, kd})
		report_mismatch($sformatf("#fe read %h, expected %h", q, {1'b1, tape_in, 1'b1, kd}));
endtask

task automatic paging_and_memory();
	byte_t       d;
	byte_t       q;
	logic [2:0]  sel;
	logic [13:0] off;
	d = byte_t'($urandom);
	off = 14'($urandom);
	write_port(16'h7ffd, 8'h13); // ram bank 3, rom 1
	write_mem({2'b11, off}, d);
	if (vram[3 * 16384 + off] !== d)
		report_mismatch($sformatf("bank 3 offset %h holds %h, expected %h", off,
			vram[3 * 16384 + off], d));
	read_mem({2'b11, off}, q);
	if (q !== d)
		report_mismatch($sformatf("ram read %h, expected %h", q, d));
	read_rom(16'h1234, q, sel);
	if (sel !== 3'd1 || q !== ~pattern(16384 + 'h1234))
		report_mismatch($sformatf("rom read ra %0d data %h with rom 1 paged", sel, q));
	write_port(16'h7ffd, 8'h23); // rom 0 and lock
	write_port(16'h7ffd, 8'h14);
	read_rom(16'h1234, q, sel);
	if (sel !== 3'd0 || q !== ~pattern('h1234))
		report_mismatch($sformatf("rom read ra %0d data %h after lock", sel, q));
	write_mem({2'b11, off}, ~d);
	if (vram[3 * 16384 + off] !== ~d || vram[4 * 16384 + off] !== pattern(4 * 16384 + off))
		report_mismatch("write after lock did not stay in bank 3");
endtask

task automatic screen_colours();
	for (int i = 0; i < 6912; i++)
		vram[5 * 16384 + i] = (i < 6144) ? 8'hff : 8'h6a; // ink 2, paper 5, bright
	goto_raster(100, 136);
	if ({r, g, b} !== colour_of(3'd2, 1'b1))
		report_mismatch($sformatf("ink rgb %b, expected %b", {r, g, b}, colour_of(3'd2, 1'b1)));
	for (int i = 0; i < 6144; i++)
		vram[5 * 16384 + i] = 8'h00;
	goto_raster(100, 136);
	if ({r, g, b} !== colour_of(3'd5, 1'b1))
		report_mismatch($sformatf("paper rgb %b, expected %b", {r, g, b},
			colour_of(3'd5, 1'b1)));
	repeat ((360 - 136) * 4) @(negedge clk28);
	if ({r, g, b} !== 6'd0)
		report_mismatch($sformatf("rgb %b during blank", {r, g, b}));
endtask

task automatic interrupt_and_sync();
	int    c;
	int    low;
	int    high;
	byte_t q;
	wait_level("n_int", 1'b0, FRAME_CYCLES + LINE_CYCLES, c);
	wait_level("n_int", 1'b1, 2 * `INT_LEN * CPU_PERIOD, low);
	if (low < `INT_LEN * CPU_PERIOD - 8 || low > `INT_LEN * CPU_PERIOD + 8)
		report_mismatch($sformatf("n_int low for %0d cycles", low));
	wait_level("n_int", 1'b0, FRAME_CYCLES, high);
	if (low + high != FRAME_CYCLES)
		report_mismatch($sformatf("n_int period %0d cycles", low + high));
	read_port(16'hffff, 1'b0, q);
	if (q !== 8'hff)
		report_mismatch($sformatf("im2 vector %h, expected ff", q));
	wait_level("hsync", 1'b0, LINE_CYCLES, c);
	wait_level("hsync", 1'b1, LINE_CYCLES, c);
	if (csync !== 1'b0)
		report_mismatch("csync high during hsync");
	wait_level("hsync", 1'b0, LINE_CYCLES, c);
	if (c != (`H_SYNC_END - `H_SYNC_START) * 4)
		report_mismatch($sformatf("hsync high for %0d cycles", c));
	wait_level("vsync", 1'b0, FRAME_CYCLES, c);
	wait_level("vsync", 1'b1, FRAME_CYCLES, c);
	if (csync !== 1'b0)
		report_mismatch("csync high during vsync");
	wait_level("vsync", 1'b0, 16 * LINE_CYCLES, c);
	if (c != 8 * LINE_CYCLES)
		report_mismatch($sformatf("vsync high for %0d cycles", c));
	wait_level("clkcpu", 1'b0, CPU_PERIOD, c);
	wait_level("clkcpu", 1'b1, CPU_PERIOD, c);
	if (n_clkcpu !== 1'b0)
		report_mismatch("n_clkcpu not low while clkcpu high");
	wait_level("clkcpu", 1'b0, CPU_PERIOD, high);
	if (n_clkcpu !== 1'b1)
		report_mismatch("n_clkcpu not high while clkcpu low");
	wait_level("clkcpu", 1'b1, CPU_PERIOD, low);
	if (high != CPU_PERIOD / 2 || low != CPU_PERIOD / 2)
		report_mismatch($sformatf("clkcpu high %0d low %0d cycles", high, low));
endtask

/* verification/zx_ula_tb.sv */
`timescale 1ns/1ps
`include "zx_ula_defines.svh"

module zx_ula_tb import zx_ula_pkg::*; ();

	localparam int CPU_PERIOD = 8; // clk28 ticks
	localparam int LINE_CYCLES = `H_TOTAL * 4;
	localparam int FRAME_CYCLES = LINE_CYCLES * `V_TOTAL;

	logic       clk28;
	logic       rst_n0;
	cpu_addr_t  xa;
	byte_t      cpu_din;
	byte_t      cpu_dout;
	logic       cpu_dout_en;
	logic       n_rd;
	logic       n_wr;
	logic       n_mreq;
	logic       n_iorqge;
	logic       n_m1;
	logic       n_rfsh;
	logic       clkcpu;
	logic       n_clkcpu;
	logic       n_int;
	logic       n_rstcpu;
	vaddr_t     va;
	byte_t      vd_in;
	byte_t      vd_out;
	logic       vd_oe;
	logic       n_vrd;
	logic       n_vwr;
	logic       n_romcs;
	logic [2:0] ra;
	logic [4:0] kd;
	logic       tape_in;
	logic       beeper;
	logic       tape_out;
	logic [1:0] r;
	logic [1:0] g;
	logic [1:0] b;
	logic       csync;
	logic       hsync;
	logic       vsync;

	byte_t vram [0:131071]; // 128k video ram
	byte_t rom [0:32767];   // two 16k rom banks
	byte_t rom_q;
	int    mismatches;
	int    timeouts;

	zx_ula i_dut (.*);

	assign vd_in = vram[va];
	assign rom_q = rom[{ra[0], xa[13:0]}];

	always #50 clk28 = ~clk28;

	always @(posedge clk28) begin
		if (!n_vwr && vd_oe)
			vram[va] <= vd_out;
	end

	function automatic byte_t pattern(input int addr);
		pattern = byte_t'(addr) ^ byte_t'(addr >> 8) ^ byte_t'(addr >> 16) ^ 8'h5a;
	endfunction

	function automatic logic probe(input string name);
		case (name)
			"n_int": probe = n_int;
			"n_rstcpu": probe = n_rstcpu;
			"n_vwr": probe = n_vwr;
			"n_romcs": probe = n_romcs;
			"cpu_dout_en": probe = cpu_dout_en;
			"clkcpu": probe = clkcpu;
			"hsync": probe = hsync;
			"vsync": probe = vsync;
			default: probe = 1'bx;
		endcase
	endfunction

	task automatic report_mismatch(input string msg);
		$display("mismatch at time %0t: %s", $time, msg);
		mismatches++;
	endtask

	task automatic finish_run();
		$display("summary: %0d mismatches, %0d timeouts", mismatches, timeouts);
		if (mismatches == 0 && timeouts == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	endtask

	// returns on a falling edge, counts the cycles spent waiting
	task automatic wait_level(input string name, input logic level, input int limit,
		output int cycles);
		cycles = 0;
		while (probe(name) !== level && cycles < limit) begin
			@(negedge clk28);
			cycles++;
		end
		if (probe(name) !== level) begin
			$display("timeout at time %0t: %s did not reach %b", $time, name, level);
			timeouts++;
		end
	endtask

	`include "zx_ula_tb_tasks.svh"

	initial begin
		void'($urandom(32'ha67abc9e));
		mismatches = 0;
		timeouts = 0;
		clk28 = 1'b0;
		rst_n0 = 1'b0;
		xa = '0;
		cpu_din = '0;
		n_rd = 1'b1;
		n_wr = 1'b1;
		n_mreq = 1'b1;
		n_iorqge = 1'b1;
		n_m1 = 1'b1;
		n_rfsh = 1'b1;
		kd = 5'h1f;
		tape_in = 1'b0;
		for (int i = 0; i < 131072; i++)
			vram[i] = pattern(i);
		for (int i = 0; i < 32768; i++)
			rom[i] = ~pattern(i);
		repeat (8) @(negedge clk28);
		rst_n0 = 1'b1;
		reset_state();
		port_fe();
		paging_and_memory();
		screen_colours();
		interrupt_and_sync();
		finish_run();
	end

endmodule

/* zx_ula.f */
+incdir+hw
+incdir+verification
hw/zx_ula_pkg.sv
hw/zx_raster_timer.sv
hw/zx_screen_fetch.sv
hw/zx_video_out.sv
hw/zx_cpu_timing.sv
hw/zx_io_ports.sv
hw/zx_mem_arbiter.sv
hw/zx_ula.sv
verification/zx_ula_tb.sv
